// ==== build.f ====
+incdir+design
design/lab_pkg.sv
design/key_decode.sv
design/flow_fifo.sv
design/rr_fifo_arbiter.sv
design/seg7_result.sv
design/lab_top.sv
verif/lab_props.sv
verif/lab_checker.sv
verif/tb_lab.sv

// ==== design/flow_fifo.sv ====
`include "lab_macros.svh"

module flow_fifo
#(
    parameter depth = `LAB_FIFO_DEPTH
)
(
    input                   clk,
    input                   rst,
    input                   push_valid,
    input  lab_pkg::data_t  push_data,
    output logic            push_ready,
    input                   pop,
    output logic            head_valid,
    output lab_pkg::data_t  head_data
);

    localparam w_ptr = $clog2 (depth);
    localparam w_cnt = $clog2 (depth + 1);

    lab_pkg::data_t      mem [depth];
    logic [w_ptr - 1:0]  wr_ptr;
    logic [w_ptr - 1:0]  rd_ptr;
    logic [w_cnt - 1:0]  count;

    logic do_push;
    logic do_pop;

    assign push_ready = (count != w_cnt' (depth));  // Not full
    assign head_valid = (count != '0);              // Not empty
    assign head_data  = mem [rd_ptr];

    assign do_push = push_valid & push_ready;
    assign do_pop  = pop & head_valid;              // Pop on empty is dropped

    function automatic logic [w_ptr - 1:0] next_ptr (input logic [w_ptr - 1:0] ptr);
        return (ptr == w_ptr' (depth - 1)) ? '0 : ptr + 1'b1;
    endfunction

    // ----------------------------------------
    // Pointers and occupancy

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (do_push)
                wr_ptr <= next_ptr (wr_ptr);
            if (do_pop)
                rd_ptr <= next_ptr (rd_ptr);

            if (do_push & ~do_pop)
                count <= count + 1'b1;
            else if (do_pop & ~do_push)
                count <= count - 1'b1;
        end
    end

    // Storage, no reset
    always_ff @(posedge clk)
    begin
        if (do_push)
            mem [wr_ptr] <= push_data;
    end

endmodule

// ==== design/key_decode.sv ====
`include "lab_macros.svh"

module key_decode
(
    input                             clk,
    input                             rst,
    input        [`LAB_W_KEY - 1:0]   key,
    input                             a_ready,
    input                             b_ready,
    output lab_pkg::key_cmd_t         cmd,
    output lab_pkg::push_t            a_push,
    output lab_pkg::push_t            b_push,
    output lab_pkg::data_t            a_next,
    output lab_pkg::data_t            b_next
);

    // Low bits only, the MSB marks the source
    logic [`LAB_W_DATA - 2:0] a_cnt;
    logic [`LAB_W_DATA - 2:0] b_cnt;

    // ----------------------------------------
    // Three-key mapping

    assign cmd.a_push    =   key [2];
    assign cmd.b_push    =   key [1];
    assign cmd.out_ready = ~ key [0];   // Ready unless the key is held

    assign a_next = { 1'b0, a_cnt };    // 0 .. 7
    assign b_next = { 1'b1, b_cnt };    // 8 .. f

    assign a_push = '{ valid: cmd.a_push, data: a_next };
    assign b_push = '{ valid: cmd.b_push, data: b_next };

    // ----------------------------------------
    // Value counters, one step per accepted push

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            a_cnt <= '0;
            b_cnt <= '0;
        end
        else
        begin
            if (a_push.valid & a_ready)
                a_cnt <= a_cnt + 1'b1;  // Wraps after 7
            if (b_push.valid & b_ready)
                b_cnt <= b_cnt + 1'b1;
        end
    end

endmodule

// ==== design/lab_macros.svh ====
`ifndef LAB_MACROS_SVH
`define LAB_MACROS_SVH

// ----------------------------------------
// Data path

`define LAB_W_DATA       4   // One FIFO value, MSB tells A from B
`define LAB_FIFO_DEPTH   4   // Entries per FIFO

// ----------------------------------------
// Board I/O

`define LAB_W_KEY        4
`define LAB_W_DIGIT      4

// Cycles each digit stays lit
// Small value keeps the scan quick in simulation
`define LAB_SCAN_CYCLES  4

`endif

// ==== design/lab_pkg.sv ====
`include "lab_macros.svh"

package lab_pkg;

    typedef logic [`LAB_W_DATA  - 1:0] data_t;
    typedef logic [              7:0] seg_t;    // abcdefgh, active high
    typedef logic [`LAB_W_DIGIT - 1:0] digit_t;  // One-hot digit select

    // Decoded key levels
    typedef struct packed
    {
        logic a_push;
        logic b_push;
        logic out_ready;   // Pop key released
    } key_cmd_t;

    // Producer offer, also used for the arbiter output
    typedef struct packed
    {
        logic  valid;
        data_t data;
    } push_t;

    typedef struct packed
    {
        logic a_ready;
        logic b_ready;
        logic out_valid;
        logic out_ready;
    } flow_status_t;

    typedef enum logic { GRANT_A, GRANT_B } grant_e;

endpackage

// ==== design/lab_top.sv ====
`include "lab_macros.svh"

module lab_top
(
    input                            clk,
    input                            rst,
    input        [`LAB_W_KEY - 1:0]  key,
    output logic [             7:0]  led,
    output lab_pkg::seg_t            abcdefgh,
    output lab_pkg::digit_t          digit
);

    lab_pkg::key_cmd_t     cmd;
    lab_pkg::push_t        a_push;
    lab_pkg::push_t        b_push;
    lab_pkg::push_t        arb_out;
    lab_pkg::data_t        a_next;
    lab_pkg::data_t        b_next;
    lab_pkg::flow_status_t status;

    logic a_ready;
    logic b_ready;

    // ----------------------------------------
    // Decode, execute, result

    key_decode i_key_decode
    (
        .clk     (clk),
        .rst     (rst),
        .key     (key),
        .a_ready (a_ready),
        .b_ready (b_ready),
        .cmd     (cmd),
        .a_push  (a_push),
        .b_push  (b_push),
        .a_next  (a_next),
        .b_next  (b_next)
    );

    rr_fifo_arbiter i_arbiter
    (
        .clk       (clk),
        .rst       (rst),
        .a_in      (a_push),
        .b_in      (b_push),
        .a_ready   (a_ready),
        .b_ready   (b_ready),
        .out       (arb_out),
        .out_ready (cmd.out_ready)
    );

    assign status = '{ a_ready:   a_ready,
                       b_ready:   b_ready,
                       out_valid: arb_out.valid,
                       out_ready: cmd.out_ready };

    seg7_result i_result
    (
        .clk      (clk),
        .rst      (rst),
        .a_next   (a_next),
        .b_next   (b_next),
        .out      (arb_out),
        .status   (status),
        .abcdefgh (abcdefgh),
        .digit    (digit)
    );

    // Handshake flags above the output value
    assign led = { status.out_ready, status.b_ready, status.a_ready,
                   status.out_valid, arb_out.data };

endmodule

// ==== design/rr_fifo_arbiter.sv ====
`include "lab_macros.svh"

module rr_fifo_arbiter
(
    input                   clk,
    input                   rst,
    input  lab_pkg::push_t  a_in,
    input  lab_pkg::push_t  b_in,
    output logic            a_ready,
    output logic            b_ready,
    output lab_pkg::push_t  out,
    input                   out_ready
);

    logic            a_head_valid;
    logic            b_head_valid;
    lab_pkg::data_t  a_head_data;
    lab_pkg::data_t  b_head_data;

    logic            pop_a;
    logic            pop_b;
    logic            sel_b;       // Offer the B head this cycle
    logic            out_fire;

    lab_pkg::grant_e last_grant;

    // ----------------------------------------
    // Source FIFOs

    flow_fifo #(.depth (`LAB_FIFO_DEPTH)) i_fifo_a
    (
        .clk        (clk),
        .rst        (rst),
        .push_valid (a_in.valid),
        .push_data  (a_in.data),
        .push_ready (a_ready),
        .pop        (pop_a),
        .head_valid (a_head_valid),
        .head_data  (a_head_data)
    );

    flow_fifo #(.depth (`LAB_FIFO_DEPTH)) i_fifo_b
    (
        .clk        (clk),
        .rst        (rst),
        .push_valid (b_in.valid),
        .push_data  (b_in.data),
        .push_ready (b_ready),
        .pop        (pop_b),
        .head_valid (b_head_valid),
        .head_data  (b_head_data)
    );

    // ----------------------------------------
    // Round-robin choice

    // B wins when A is empty, or when both wait and A went last
    assign sel_b = b_head_valid & (~a_head_valid | (last_grant == lab_pkg::GRANT_A));

    assign out.valid = a_head_valid | b_head_valid;
    assign out.data  = sel_b ? b_head_data : a_head_data;

    assign out_fire = out.valid & out_ready;
    assign pop_a    = out_fire & ~sel_b;
    assign pop_b    = out_fire &  sel_b;

    // Held under back-pressure
    always_ff @(posedge clk)
    begin
        if (rst)
            last_grant <= lab_pkg::GRANT_B;   // A goes first
        else if (out_fire)
            last_grant <= sel_b ? lab_pkg::GRANT_B : lab_pkg::GRANT_A;
    end

endmodule

// ==== design/seg7_result.sv ====
`include "lab_macros.svh"

module seg7_result
(
    input                          clk,
    input                          rst,
    input  lab_pkg::data_t         a_next,
    input  lab_pkg::data_t         b_next,
    input  lab_pkg::push_t         out,
    input  lab_pkg::flow_status_t  status,
    output lab_pkg::seg_t          abcdefgh,
    output lab_pkg::digit_t        digit
);

    localparam w_scan = $clog2 (`LAB_SCAN_CYCLES);

    localparam lab_pkg::seg_t sign_a       = 8'b1000_0000,
                              sign_g       = 8'b0000_0010,
                              sign_d       = 8'b0001_0000,
                              sign_nothing = 8'b0000_0000;

    logic [w_scan - 1:0] scan_cnt;

    function automatic lab_pkg::seg_t hex_seg (input lab_pkg::data_t value);
        case (value)
            4'h0: return 8'hfc;
            4'h1: return 8'h60;
            4'h2: return 8'hda;
            4'h3: return 8'hf2;
            4'h4: return 8'h66;
            4'h5: return 8'hb6;
            4'h6: return 8'hbe;
            4'h7: return 8'he0;
            4'h8: return 8'hfe;
            4'h9: return 8'hf6;
            4'ha: return 8'hee;
            4'hb: return 8'h3e;
            4'hc: return 8'h9c;
            4'hd: return 8'h7a;
            4'he: return 8'h9e;
            default: return 8'h8e;  // f
        endcase
    endfunction

    // ----------------------------------------
    // Digit scan

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            scan_cnt <= '0;
            digit    <= `LAB_W_DIGIT'(1);
        end
        else if (scan_cnt == w_scan' (`LAB_SCAN_CYCLES - 1))
        begin
            scan_cnt <= '0;
            digit    <= { digit [`LAB_W_DIGIT - 2:0], digit [`LAB_W_DIGIT - 1] };
        end
        else
            scan_cnt <= scan_cnt + 1'b1;
    end

    // ----------------------------------------
    // Segment pattern for the lit digit

    always_comb
    begin
        case (digit)
            4'b1000: abcdefgh = hex_seg (a_next);
            4'b0100: abcdefgh = hex_seg (b_next);
            4'b0010:
            begin
                abcdefgh = sign_nothing;     // One segment per ready flag
                if (status.a_ready)   abcdefgh |= sign_a;
                if (status.b_ready)   abcdefgh |= sign_g;
                if (status.out_ready) abcdefgh |= sign_d;
            end
            4'b0001: abcdefgh = out.valid ? hex_seg (out.data) : sign_nothing;
            default: abcdefgh = sign_nothing;
        endcase
    end

endmodule

// ==== run.sh ====
#!/bin/sh
set -e

# Build the testbench with the lab top level below it
verilator --binary --assert -f build.f --top-module tb_lab -o sim_lab

# Keep the output even when the simulator exits with an error
out=$(./obj_dir/sim_lab || true)
echo "$out"

if echo "$out" | grep -qx "Verification passed"; then
    exit 0
else
    exit 1
fi

// ==== verif/lab_checker.sv ====
`include "lab_macros.svh"

module lab_checker
(
    input                   clk,
    input                   rst,
    input  [3:0]            key,
    input  [7:0]            led,
    input  lab_pkg::seg_t   abcdefgh,
    input  lab_pkg::digit_t digit,
    input  [79:0]           test_name,
    input                   test_end,
    output int              tests_run,
    output int              tests_failed,
    output int              error_count
);

    timeunit 1ns;
    timeprecision 100ps;

    lab_pkg::data_t  fifo_a [$];    // Model FIFOs
    lab_pkg::data_t  fifo_b [$];
    logic [2:0]      cnt_a;
    logic [2:0]      cnt_b;
    logic            last_b;        // Last grant went to B
    logic            was_stalled;
    lab_pkg::data_t  stalled_data;
    lab_pkg::digit_t exp_digit;     // Digit the scan should be on
    int              scan_count;
    int              test_errors;
    int              transfers;

    // Segments abcdefgh, h is the dot and stays dark
    function automatic lab_pkg::seg_t hex_pattern (input lab_pkg::data_t v);
        case (v)
            4'h0: return 8'b1111_1100;
            4'h1: return 8'b0110_0000;
            4'h2: return 8'b1101_1010;
            4'h3: return 8'b1111_0010;
            4'h4: return 8'b0110_0110;
            4'h5: return 8'b1011_0110;
            4'h6: return 8'b1011_1110;
            4'h7: return 8'b1110_0000;
            4'h8: return 8'b1111_1110;
            4'h9: return 8'b1111_0110;
            4'ha: return 8'b1110_1110;
            4'hb: return 8'b0011_1110;
            4'hc: return 8'b1001_1100;
            4'hd: return 8'b0111_1010;
            4'he: return 8'b1001_1110;
            default: return 8'b1000_1110;
        endcase
    endfunction

    task automatic flag_error (input string msg);
        $display ("error at %0d ns: %s", $time, msg);
        error_count++;
        test_errors++;
    endtask

    // ----------------------------------------
    // Sample mid-cycle, then step the model

    always @(negedge clk)
    begin
        logic           exp_valid;
        logic           sel_b;
        lab_pkg::data_t head;
        lab_pkg::seg_t  exp_seg;
        if (rst)
        begin
            fifo_a.delete ();
            fifo_b.delete ();
            cnt_a        = '0;
            cnt_b        = '0;
            last_b       = 1'b1;   // A offered first
            was_stalled  = 1'b0;
            stalled_data = '0;
            exp_digit    = 4'b0001;
            scan_count   = 0;
            test_errors  = 0;
            transfers    = 0;
            tests_run    = 0;
            tests_failed = 0;
            error_count  = 0;
        end
        else
        begin
            exp_valid = (fifo_a.size () != 0) || (fifo_b.size () != 0);
            sel_b     = (fifo_b.size () != 0) && ((fifo_a.size () == 0) || !last_b);
            head      = '0;
            if (exp_valid)
                head = sel_b ? fifo_b [0] : fifo_a [0];

            // Ready flags on digit 1 as segments a, d and g
            case (exp_digit)
                4'b1000: exp_seg = hex_pattern ({ 1'b0, cnt_a });
                4'b0100: exp_seg = hex_pattern ({ 1'b1, cnt_b });
                4'b0010: exp_seg = { led [5], 2'b00, !key [0], 2'b00, led [6], 1'b0 };
                default: exp_seg = led [4] ? hex_pattern (led [3:0]) : 8'h00;
            endcase

            if (led [4] != exp_valid)
                flag_error ($sformatf ("out_valid %b, expected %b", led [4], exp_valid));
            if (led [5] != (fifo_a.size () < `LAB_FIFO_DEPTH))
                flag_error ($sformatf ("a_ready %b with %0d in FIFO A", led [5], fifo_a.size ()));
            if (led [6] != (fifo_b.size () < `LAB_FIFO_DEPTH))
                flag_error ($sformatf ("b_ready %b with %0d in FIFO B", led [6], fifo_b.size ()));
            if (led [7] != !key [0])
                flag_error ($sformatf ("out_ready %b with key[0] %b", led [7], key [0]));
            if (exp_valid && led [3:0] != head)
                flag_error ($sformatf ("out data %h, expected %h", led [3:0], head));
            if (was_stalled && (!led [4] || led [3:0] != stalled_data))
                flag_error ($sformatf ("out moved under back-pressure, %h to %h",
                                       stalled_data, led [3:0]));
            if (digit != exp_digit)
                flag_error ($sformatf ("digit %b, expected %b", digit, exp_digit));
            else if (abcdefgh != exp_seg)
                flag_error ($sformatf ("digit %b shows %b, expected %b",
                                       digit, abcdefgh, exp_seg));

            if (exp_valid && !key [0])     // Output transfer
            begin
                if (sel_b)
                    void' (fifo_b.pop_front ());
                else
                    void' (fifo_a.pop_front ());
                last_b = sel_b;
                transfers++;
            end
            if (key [2] && led [5])
            begin
                fifo_a.push_back ({ 1'b0, cnt_a });
                cnt_a = cnt_a + 3'd1;
            end
            if (key [1] && led [6])
            begin
                fifo_b.push_back ({ 1'b1, cnt_b });
                cnt_b = cnt_b + 3'd1;
            end
            was_stalled  = exp_valid && key [0];
            stalled_data = led [3:0];

            // Scan moves one digit to the left
            if (scan_count == `LAB_SCAN_CYCLES - 1)
            begin
                scan_count = 0;
                exp_digit  = { exp_digit [2:0], exp_digit [3] };
            end
            else
                scan_count++;

            if (test_end)
            begin
                tests_run++;
                if (test_errors != 0)
                    tests_failed++;
                $display ("%s  %s  pops %0d  errors %0d", test_name,
                          (test_errors == 0) ? "ok" : "FAILED", transfers, test_errors);
                test_errors = 0;
                transfers   = 0;
            end
        end
    end

endmodule

// ==== verif/lab_props.sv ====
`include "lab_macros.svh"

module lab_props
(
    input                  clk,
    input                  rst,
    input lab_pkg::push_t  a_in,
    input lab_pkg::push_t  b_in,
    input lab_pkg::push_t  out,
    input                  a_ready,
    input                  b_ready,
    input                  out_ready,
    input                  pop_a,
    input                  pop_b
);

    timeunit 1ns;
    timeprecision 100ps;

    logic [2:0] a_level;   // Occupancy seen from the handshakes
    logic [2:0] b_level;
    logic       pushed;    // Any push since reset

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            a_level <= '0;
            b_level <= '0;
            pushed  <= 1'b0;
        end
        else
        begin
            a_level <= a_level + 3' (a_in.valid & a_ready) - 3' (pop_a);
            b_level <= b_level + 3' (b_in.valid & b_ready) - 3' (pop_b);
            if ((a_in.valid & a_ready) | (b_in.valid & b_ready))
                pushed <= 1'b1;
        end
    end

    // ----------------------------------------
    // Handshake rules

    hold_under_stall: assert property (@(posedge clk) disable iff (rst)
        out.valid && !out_ready |=> out.valid && $stable (out.data))
        else $error ("output changed while stalled");

    a_full_not_ready: assert property (@(posedge clk) disable iff (rst)
        a_level == `LAB_FIFO_DEPTH |-> !a_ready)
        else $error ("a_ready high with FIFO A full");

    b_full_not_ready: assert property (@(posedge clk) disable iff (rst)
        b_level == `LAB_FIFO_DEPTH |-> !b_ready)
        else $error ("b_ready high with FIFO B full");

    quiet_after_reset: assert property (@(posedge clk) disable iff (rst)
        !pushed |-> !out.valid)
        else $error ("output valid before any push");

endmodule

// ==== verif/tb_lab.sv ====
module tb_lab;

    timeunit 1ns;
    timeprecision 100ps;

    localparam n_rows = 8;

    typedef struct packed
    {
        logic [3:0] key;
        logic [7:0] hold;          // Cycles this key value is held
    } step_t;

    typedef struct packed
    {
        logic [79:0]     name;
        logic [7:0]      cycles;   // Row length, keys idle after the last step
        logic            rnd;      // Random key[0] every cycle
        step_t [0:3]     steps;
    } row_t;

    logic                clk = 1'b0;
    logic                rst;
    logic [3:0]          key;
    logic [7:0]          led;
    lab_pkg::seg_t       abcdefgh;
    lab_pkg::digit_t     digit;
    logic [79:0]         test_name;
    logic                test_end;
    int                  tests_run;
    int                  tests_failed;
    int                  error_count;
    int                  cycle_cnt = 0;
    int                  limit = 0;
    row_t                rows [n_rows];

    always #4 clk = ~clk;

    lab_top i_lab_top (.clk (clk), .rst (rst), .key (key), .led (led),
                       .abcdefgh (abcdefgh), .digit (digit));

    lab_checker i_checker (.clk (clk), .rst (rst), .key (key), .led (led),
                           .abcdefgh (abcdefgh), .digit (digit),
                           .test_name (test_name), .test_end (test_end),
                           .tests_run (tests_run), .tests_failed (tests_failed),
                           .error_count (error_count));

    bind rr_fifo_arbiter lab_props i_props (.clk (clk), .rst (rst), .a_in (a_in),
        .b_in (b_in), .out (out), .a_ready (a_ready), .b_ready (b_ready),
        .out_ready (out_ready), .pop_a (pop_a), .pop_b (pop_b));

    function automatic logic [3:0] key_at (input row_t row, input int cycle);
        int start;
        start = 0;
        for (int s = 0; s < 4; s++)
        begin
            if (cycle < start + int' (row.steps [s].hold))
                return row.steps [s].key;
            start += int' (row.steps [s].hold);
        end
        return 4'h0;
    endfunction

    // ----------------------------------------
    // Stimulus table, step is key then hold

    initial
    begin
        logic [3:0] next_key;
        void' ($urandom (32'h8c2));
        rows [0] = '{ "reset_idle", 8'd6,  1'b0, { 12'h0_06, 12'h0_00, 12'h0_00, 12'h0_00 } };
        rows [1] = '{ "alternates", 8'd14, 1'b0, { 12'h7_02, 12'h3_02, 12'h0_00, 12'h0_00 } };
        rows [2] = '{ "a_in_order", 8'd10, 1'b0, { 12'h5_03, 12'h0_00, 12'h0_00, 12'h0_00 } };
        rows [3] = '{ "a_wrapping", 8'd22, 1'b0, { 12'h5_04, 12'h0_06, 12'h5_04, 12'h0_06 } };
        rows [4] = '{ "a_full_gap", 8'd18, 1'b0, { 12'h5_06, 12'h0_06, 12'h5_01, 12'h0_00 } };
        rows [5] = '{ "held_stall", 8'd18, 1'b0, { 12'h7_02, 12'h1_06, 12'h0_00, 12'h0_00 } };
        rows [6] = '{ "rand_stall", 8'd44, 1'b1, { 12'h6_0a, 12'h0_00, 12'h0_00, 12'h0_00 } };
        rows [7] = '{ "drain_tail", 8'd8,  1'b0, { 12'h0_08, 12'h0_00, 12'h0_00, 12'h0_00 } };

        limit = 50;
        for (int r = 0; r < n_rows; r++)
            limit += int' (rows [r].cycles);

        rst       = 1'b1;
        key       = '0;
        test_name = '0;
        test_end  = 1'b0;
        repeat (4) @(posedge clk);
        rst <= 1'b0;

        for (int r = 0; r < n_rows; r++)
        begin
            for (int c = 0; c < int' (rows [r].cycles); c++)
            begin
                @(posedge clk);
                next_key = key_at (rows [r], c);
                if (rows [r].rnd)
                    next_key [0] = 1' ($urandom);
                key       <= next_key;
                test_name <= rows [r].name;
                test_end  <= (c == int' (rows [r].cycles) - 1);
            end
        end
        @(posedge clk);
        key      <= '0;
        test_end <= 1'b0;
        @(posedge clk);

        $display ("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, error_count);
        if (error_count == 0 && tests_run == n_rows)
            $display ("Verification passed");
        else
            $display ("Verification failed");
        $finish;
    end

    // Watchdog
    always @(posedge clk)
    begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= limit)
        begin
            $display ("timeout: run did not finish within %0d cycles", limit);
            $display ("Verification failed");
            $finish;
        end
    end

endmodule
